//--- compile.f
+incdir+verif
design/mipsPkg.sv
design/instrDecoder.sv
design/regFile.sv
design/aluUnit.sv
design/coreControl.sv
design/mipsCore.sv
verif/tbClock.sv
verif/tbTop.sv

//--- design/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  logic [mipsPkg::dataWidth-1:0]  opA,
    input  logic [mipsPkg::dataWidth-1:0]  opB,
    input  logic [mipsPkg::regIdWidth-1:0] shamt,
    input  mipsPkg::aluOpE                 aluOp,
    output logic [mipsPkg::dataWidth-1:0]  aluResult,
    output logic                           zero
);
    import mipsPkg::*;

    always_comb begin
        case (aluOp)
            aluAdd:             aluResult = opA + opB;
            aluSub:             aluResult = opA - opB;
            aluAnd:             aluResult = opA & opB;
            aluOr:              aluResult = opA | opB;
            aluXor:             aluResult = opA ^ opB;
            aluNor:             aluResult = ~(opA | opB);
            aluSetLess:         aluResult = dataWidth'($signed(opA) < $signed(opB));
            aluSetLessUnsigned: aluResult = dataWidth'(opA < opB);
            aluShiftLeft:       aluResult = opB << shamt; // Shifts act on rt.
            aluShiftRight:      aluResult = opB >> shamt;
            aluShiftRightArith: aluResult = $signed(opB) >>> shamt;
            aluLoadUpper:       aluResult = opB << 16;
            default:            aluResult = '0;
        endcase
    end

    assign zero = (opA == opB);

endmodule

//--- design/coreControl.sv
`timescale 1ns/1ps

module coreControl #(
    parameter int memDepthWords = 1024
) (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic [mipsPkg::dataWidth-1:0]  memRData,
    input  logic [mipsPkg::regIdWidth-1:0] shamt,
    input  logic [15:0]                    imm16,
    input  logic [25:0]                    imm26,
    input  mipsPkg::aluOpE                 aluOp,
    input  logic                           useImm,
    input  logic                           signExtImm,
    input  logic                           memLoad,
    input  logic                           memStore,
    input  logic                           linkWrite,
    input  logic                           breakHit,
    input  logic                           regWriteEnable,
    input  mipsPkg::branchE                branchKind,
    input  logic [mipsPkg::regIdWidth-1:0] writeRegId,
    input  logic [mipsPkg::dataWidth-1:0]  rsData,
    input  logic [mipsPkg::dataWidth-1:0]  rtData,
    input  logic [mipsPkg::dataWidth-1:0]  aluResult,
    input  logic                           zero,
    output logic [mipsPkg::dataWidth-1:0]  instr,
    output logic [mipsPkg::dataWidth-1:0]  opA,
    output logic [mipsPkg::dataWidth-1:0]  opB,
    output logic [mipsPkg::regIdWidth-1:0] shamtOut,
    output mipsPkg::aluOpE                 aluOpOut,
    output logic                           memRead,
    output logic                           memWrite,
    output logic [mipsPkg::dataWidth-1:0]  memAddr,
    output logic [mipsPkg::dataWidth-1:0]  memWData,
    output logic                           rfWrite,
    output logic [mipsPkg::regIdWidth-1:0] rfWriteId,
    output logic [mipsPkg::dataWidth-1:0]  rfWriteData,
    output logic                           retire,
    output logic [mipsPkg::dataWidth-1:0]  retirePc,
    output logic                           halted
);
    import mipsPkg::*;

    localparam logic [dataWidth-1:0] addrMask = dataWidth'(memDepthWords * 4 - 4);

    phaseE                phase;
    logic                 memWait;
    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] nextPc;
    logic [dataWidth-1:0] instrReg;
    logic [dataWidth-1:0] rsReg;
    logic [dataWidth-1:0] rtReg;
    logic [dataWidth-1:0] resultReg;
    logic [dataWidth-1:0] pcPlus4;
    logic [dataWidth-1:0] extImm;
    logic [dataWidth-1:0] branchTarget;
    logic [dataWidth-1:0] jumpTarget;
    logic [dataWidth-1:0] pcSelect;
    logic                 isMove;

    assign instr  = (phase == phDecode) ? memRData : instrReg; // Fetched word goes straight in.
    assign isMove = (instrReg[31:26] == opSpecial) &&
                    ((instrReg[5:0] == fnMovn) || (instrReg[5:0] == fnMovz));

    assign extImm       = signExtImm ? {{(dataWidth-16){imm16[15]}}, imm16}
                                     : {{(dataWidth-16){1'b0}}, imm16};
    assign pcPlus4      = pc + dataWidth'(4);
    assign branchTarget = pcPlus4 + {extImm[dataWidth-3:0], 2'b00};
    assign jumpTarget   = {pc[dataWidth-1 -: 4], imm26, 2'b00};

    always_comb begin
        case (branchKind)
            brEqual:    pcSelect = zero ? branchTarget : pcPlus4;
            brNotEqual: pcSelect = zero ? pcPlus4 : branchTarget;
            brJump:     pcSelect = jumpTarget;
            brJumpReg:  pcSelect = rsReg;
            default:    pcSelect = pcPlus4;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase   <= phFetch;
            pc      <= '0;
            memWait <= 1'b0;
        end else begin
            case (phase)
                phFetch:     phase <= phDecode;
                phDecode:    phase <= phExecute;
                phExecute:   phase <= (memLoad || memStore) ? phMemory : phWriteBack;
                phMemory: begin
                    if (memLoad && !memWait) begin
                        memWait <= 1'b1; // Load data shows up next cycle.
                    end else begin
                        memWait <= 1'b0;
                        phase   <= phWriteBack;
                    end
                end
                phWriteBack: begin
                    pc    <= nextPc;
                    phase <= breakHit ? phHalted : phFetch;
                end
                default:     phase <= phHalted;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (phase)
            phDecode: begin
                instrReg <= memRData;
                rsReg    <= rsData;
                rtReg    <= rtData;
            end
            phExecute: begin
                resultReg <= isMove ? rsReg : aluResult;
                nextPc    <= pcSelect;
            end
            phMemory: begin
                if (memWait) begin
                    resultReg <= memRData;
                end
            end
            default: ;
        endcase
    end

    assign opA      = rsReg;
    assign opB      = useImm ? extImm : rtReg;
    assign shamtOut = shamt;
    assign aluOpOut = aluOp;

    assign memRead  = (phase == phFetch) || ((phase == phMemory) && memLoad && !memWait);
    assign memWrite = (phase == phMemory) && memStore;
    assign memAddr  = ((phase == phMemory) ? resultReg : pc) & addrMask;
    assign memWData = rtReg;

    assign rfWrite     = (phase == phWriteBack) && regWriteEnable;
    assign rfWriteId   = writeRegId;
    assign rfWriteData = linkWrite ? pcPlus4 : resultReg; // jal links the return address.
    assign retire      = (phase == phWriteBack);
    assign retirePc    = pc;
    assign halted      = (phase == phHalted);

    assert property (@(posedge clk) disable iff (!rstN) !(memRead && memWrite));

endmodule

//--- design/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  logic [mipsPkg::dataWidth-1:0]  instr,
    input  logic [mipsPkg::dataWidth-1:0]  rtData,
    output logic [mipsPkg::regIdWidth-1:0] rs,
    output logic [mipsPkg::regIdWidth-1:0] rt,
    output logic [mipsPkg::regIdWidth-1:0] rd,
    output logic [mipsPkg::regIdWidth-1:0] shamt,
    output logic [15:0]                    imm16,
    output logic [25:0]                    imm26,
    output mipsPkg::aluOpE                 aluOp,
    output logic                           useImm,
    output logic                           signExtImm,
    output logic                           memLoad,
    output logic                           memStore,
    output logic                           linkWrite,
    output logic                           breakHit,
    output logic                           regWriteEnable,
    output mipsPkg::branchE                branchKind,
    output logic [mipsPkg::regIdWidth-1:0] writeRegId
);
    import mipsPkg::*;

    opCodeE opCode;
    functE  funct;
    logic   writes;
    logic   rtDest;

    assign opCode = opCodeE'(instr[31:26]);
    assign funct  = functE'(instr[5:0]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign imm16  = instr[15:0];
    assign imm26  = instr[25:0];

    assign memLoad   = (opCode == opLoadWord);
    assign memStore  = (opCode == opStoreWord);
    assign linkWrite = (opCode == opJumpAndLink);
    assign breakHit  = (opCode == opSpecial) && (funct == fnBreak);

    always_comb begin
        aluOp      = aluAdd;
        useImm     = 1'b1;
        signExtImm = 1'b1;
        branchKind = brNone;
        writes     = 1'b0;
        rtDest     = 1'b1;
        case (opCode)
            opSpecial: begin
                useImm = 1'b0;
                rtDest = 1'b0;
                writes = 1'b1;
                case (funct)
                    fnSll:     aluOp = aluShiftLeft;
                    fnSrl:     aluOp = aluShiftRight;
                    fnSra:     aluOp = aluShiftRightArith;
                    fnAddu:    aluOp = aluAdd;
                    fnSubu:    aluOp = aluSub;
                    fnAnd:     aluOp = aluAnd;
                    fnOr:      aluOp = aluOr;
                    fnXor:     aluOp = aluXor;
                    fnNor:     aluOp = aluNor;
                    fnSlt:     aluOp = aluSetLess;
                    fnSltu:    aluOp = aluSetLessUnsigned;
                    fnMovn:    writes = (rtData != '0); // Move only if rt is nonzero.
                    fnMovz:    writes = (rtData == '0);
                    fnJumpReg: begin
                        branchKind = brJumpReg;
                        writes     = 1'b0;
                    end
                    default:   writes = 1'b0; // Break and unknown codes write nothing.
                endcase
            end
            opAddiu:          writes = 1'b1;
            opSlti: begin
                aluOp  = aluSetLess;
                writes = 1'b1;
            end
            opSltiu: begin
                aluOp  = aluSetLessUnsigned;
                writes = 1'b1;
            end
            opAndi: begin
                aluOp      = aluAnd;
                signExtImm = 1'b0;
                writes     = 1'b1;
            end
            opOri: begin
                aluOp      = aluOr;
                signExtImm = 1'b0;
                writes     = 1'b1;
            end
            opXori: begin
                aluOp      = aluXor;
                signExtImm = 1'b0;
                writes     = 1'b1;
            end
            opLui: begin
                aluOp      = aluLoadUpper;
                signExtImm = 1'b0;
                writes     = 1'b1;
            end
            opLoadWord:       writes = 1'b1;
            opBranchEqual: begin
                useImm     = 1'b0; // Branches compare rs with rt.
                branchKind = brEqual;
            end
            opBranchNotEqual: begin
                useImm     = 1'b0;
                branchKind = brNotEqual;
            end
            opJump:           branchKind = brJump;
            opJumpAndLink: begin
                branchKind = brJump;
                writes     = 1'b1;
            end
            default: ;
        endcase
    end

    assign writeRegId     = linkWrite ? regIdWidth'(31) : (rtDest ? rt : rd);
    assign regWriteEnable = writes && (writeRegId != '0); // Register 0 is never written.

endmodule

//--- design/mipsCore.sv
`timescale 1ns/1ps

module mipsCore #(
    parameter int memDepthWords = 1024
) (
    input  logic                           clk,
    input  logic                           rstN,
    output logic                           memRead,
    output logic                           memWrite,
    output logic [mipsPkg::dataWidth-1:0]  memAddr,
    output logic [mipsPkg::dataWidth-1:0]  memWData,
    input  logic [mipsPkg::dataWidth-1:0]  memRData,
    output logic                           retire,
    output logic [mipsPkg::dataWidth-1:0]  retirePc,
    output logic                           regWriteEnable,
    output logic [mipsPkg::regIdWidth-1:0] writeRegId,
    output logic [mipsPkg::dataWidth-1:0]  writeData,
    output logic                           halted
);
    import mipsPkg::*;

    logic [dataWidth-1:0]  instr;
    logic [regIdWidth-1:0] rs;
    logic [regIdWidth-1:0] rt;
    logic [regIdWidth-1:0] shamt;
    logic [regIdWidth-1:0] shamtOut;
    logic [15:0]           imm16;
    logic [25:0]           imm26;
    aluOpE                 aluOp;
    aluOpE                 aluOpOut;
    logic                  useImm;
    logic                  signExtImm;
    logic                  memLoad;
    logic                  memStore;
    logic                  linkWrite;
    logic                  breakHit;
    logic                  decWriteEnable;
    logic [regIdWidth-1:0] decWriteId;
    branchE                branchKind;
    logic [dataWidth-1:0]  rsData;
    logic [dataWidth-1:0]  rtData;
    logic [dataWidth-1:0]  opA;
    logic [dataWidth-1:0]  opB;
    logic [dataWidth-1:0]  aluResult;
    logic                  zero;

    instrDecoder decoder (
        .instr          (instr),
        .rtData         (rtData),
        .rs             (rs),
        .rt             (rt),
        .rd             (),
        .shamt          (shamt),
        .imm16          (imm16),
        .imm26          (imm26),
        .aluOp          (aluOp),
        .useImm         (useImm),
        .signExtImm     (signExtImm),
        .memLoad        (memLoad),
        .memStore       (memStore),
        .linkWrite      (linkWrite),
        .breakHit       (breakHit),
        .regWriteEnable (decWriteEnable),
        .branchKind     (branchKind),
        .writeRegId     (decWriteId)
    );

    regFile registers (
        .clk         (clk),
        .rstN        (rstN),
        .rs          (rs),
        .rt          (rt),
        .writeEnable (regWriteEnable),
        .writeId     (writeRegId),
        .writeData   (writeData),
        .rsData      (rsData),
        .rtData      (rtData)
    );

    aluUnit alu (
        .opA       (opA),
        .opB       (opB),
        .shamt     (shamtOut),
        .aluOp     (aluOpOut),
        .aluResult (aluResult),
        .zero      (zero)
    );

    coreControl #(
        .memDepthWords (memDepthWords)
    ) control (
        .clk            (clk),
        .rstN           (rstN),
        .memRData       (memRData),
        .shamt          (shamt),
        .imm16          (imm16),
        .imm26          (imm26),
        .aluOp          (aluOp),
        .useImm         (useImm),
        .signExtImm     (signExtImm),
        .memLoad        (memLoad),
        .memStore       (memStore),
        .linkWrite      (linkWrite),
        .breakHit       (breakHit),
        .regWriteEnable (decWriteEnable),
        .branchKind     (branchKind),
        .writeRegId     (decWriteId),
        .rsData         (rsData),
        .rtData         (rtData),
        .aluResult      (aluResult),
        .zero           (zero),
        .instr          (instr),
        .opA            (opA),
        .opB            (opB),
        .shamtOut       (shamtOut),
        .aluOpOut       (aluOpOut),
        .memRead        (memRead),
        .memWrite       (memWrite),
        .memAddr        (memAddr),
        .memWData       (memWData),
        .rfWrite        (regWriteEnable),
        .rfWriteId      (writeRegId),
        .rfWriteData    (writeData),
        .retire         (retire),
        .retirePc       (retirePc),
        .halted         (halted)
    );

endmodule

//--- design/mipsPkg.sv
package mipsPkg;

    parameter int dataWidth = 32;
    parameter int regIdWidth = 5;

    typedef enum logic [5:0] {
        opSpecial        = 6'h00,
        opJump           = 6'h02,
        opJumpAndLink    = 6'h03,
        opBranchEqual    = 6'h04,
        opBranchNotEqual = 6'h05,
        opAddiu          = 6'h09,
        opSlti           = 6'h0a,
        opSltiu          = 6'h0b,
        opAndi           = 6'h0c,
        opOri            = 6'h0d,
        opXori           = 6'h0e,
        opLui            = 6'h0f,
        opLoadWord       = 6'h23,
        opStoreWord      = 6'h2b
    } opCodeE;

    typedef enum logic [5:0] {
        fnSll     = 6'h00,
        fnSrl     = 6'h02,
        fnSra     = 6'h03,
        fnJumpReg = 6'h08,
        fnMovz    = 6'h0a,
        fnMovn    = 6'h0b,
        fnBreak   = 6'h0d,
        fnAddu    = 6'h21,
        fnSubu    = 6'h23,
        fnAnd     = 6'h24,
        fnOr      = 6'h25,
        fnXor     = 6'h26,
        fnNor     = 6'h27,
        fnSlt     = 6'h2a,
        fnSltu    = 6'h2b
    } functE;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSetLess,
        aluSetLessUnsigned,
        aluShiftLeft,
        aluShiftRight,
        aluShiftRightArith,
        aluLoadUpper
    } aluOpE;

    typedef enum logic [2:0] {
        brNone,
        brEqual,
        brNotEqual,
        brJump,
        brJumpReg
    } branchE;

    typedef enum logic [2:0] {
        phFetch,
        phDecode,
        phExecute,
        phMemory,
        phWriteBack,
        phHalted
    } phaseE;

endpackage

//--- design/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic [mipsPkg::regIdWidth-1:0] rs,
    input  logic [mipsPkg::regIdWidth-1:0] rt,
    input  logic                           writeEnable,
    input  logic [mipsPkg::regIdWidth-1:0] writeId,
    input  logic [mipsPkg::dataWidth-1:0]  writeData,
    output logic [mipsPkg::dataWidth-1:0]  rsData,
    output logic [mipsPkg::dataWidth-1:0]  rtData
);
    import mipsPkg::*;

    logic [dataWidth-1:0] regs [2**regIdWidth];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 2**regIdWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeId] <= writeData;
        end
    end

    assign rsData = (rs == '0) ? '0 : regs[rs];
    assign rtData = (rt == '0) ? '0 : regs[rt];

    // The decoder drops register 0 writes before they get here.
    assert property (@(posedge clk) disable iff (!rstN) writeEnable |-> writeId != '0);

endmodule

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tbTop -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- verif/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
    parameter int periodNs    = 40,
    parameter int resetCycles = 16
) (
    input  logic resetReq,
    output logic clk,
    output logic rstN
);
    int count = 0;

    initial begin
        clk  = 1'b0;
        rstN = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (resetReq) begin
            count <= 0;
        end else if (count < resetCycles) begin
            count <= count + 1;
        end
    end

    // Reset changes on the falling edge, away from the core's flops.
    always @(negedge clk) begin
        rstN <= (count >= resetCycles);
    end

endmodule

//--- verif/tbModel.svh
logic [31:0]          randState;
logic [dataWidth-1:0] modelRegs [32];
logic [dataWidth-1:0] modelMem [memDepth];
logic [dataWidth-1:0] modelPc;
logic [dataWidth-1:0] mPc;
logic [dataWidth-1:0] mData;
logic [dataWidth-1:0] mStoreAddr;
logic [dataWidth-1:0] mStoreData;
logic [regIdWidth-1:0] mId;
logic                 mWe;
logic                 mStore;
logic                 modelHalt;

function logic [31:0] nextRand();
    randState = randState ^ (randState << 13);
    randState = randState ^ (randState >> 17);
    randState = randState ^ (randState << 5);
    return randState;
endfunction

// Background contents, different for every word address.
function logic [dataWidth-1:0] fillWord(input int idx);
    logic [31:0] a;
    a = 32'(idx);
    return (a * 32'h9e3779b1) ^ {a[15:0], ~a[15:0]};
endfunction

function logic [5:0] aluFunct(input logic [2:0] sel);
    case (sel)
        3'd0:    return 6'h21;
        3'd1:    return 6'h23;
        3'd2:    return 6'h24;
        3'd3:    return 6'h25;
        3'd4:    return 6'h26;
        3'd5:    return 6'h27;
        3'd6:    return 6'h2a;
        default: return 6'h2b;
    endcase
endfunction

task automatic genProgram();
    int          i;
    int          kind;
    int          t;
    logic [31:0] r;
    logic [31:0] w;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [4:0]  rc;
    logic [5:0]  op;
    bit          isTarget [progLen];
    for (int k = 0; k < memDepth; k++) begin
        mem[k]      = fillWord(k);
        modelMem[k] = fillWord(k);
    end
    for (int k = 0; k < progLen; k++) begin
        isTarget[k] = 1'b0;
    end
    i = 0;
    while (i < progLen - 1) begin
        r    = nextRand();
        ra   = r[4:0];
        rb   = r[9:5];
        rc   = r[14:10];
        kind = int'(nextRand() % 20);
        case (kind)
            0, 1, 2, 3: w = {6'h00, ra, rb, rc, 5'd0, aluFunct(r[17:15])};
            4: begin
                op = (r[16:15] == 2'd1) ? 6'h02 : ((r[16:15] == 2'd2) ? 6'h03 : 6'h00);
                w  = {6'h00, 5'd0, rb, rc, r[21:17], op};
            end
            5: w = {6'h00, ra, rb, rc, 5'd0, r[15] ? 6'h0b : 6'h0a};
            6, 7, 8, 9: begin
                op = 6'(9 + int'(r[18:16] % 3'd7));
                w  = {op, ra, rb, r[31:16]};
            end
            10, 11: w = {r[15] ? 6'h23 : 6'h2b, 5'd0, rb, 10'h020, r[19:16], 2'b00}; // Data at 0x800.
            12, 13: begin
                t  = i + 1 + int'(nextRand() % 32'(progLen - 1 - i));
                isTarget[t] = 1'b1;
                rb = r[16] ? ra : rb; // Equal operands make taken branches common.
                w  = {r[15] ? 6'h05 : 6'h04, ra, rb, 16'(t - i - 1)};
            end
            14: begin
                t = i + 1 + int'(nextRand() % 32'(progLen - 1 - i));
                isTarget[t] = 1'b1;
                w = {r[15] ? 6'h03 : 6'h02, 26'(t)};
            end
            15: begin
                if (i + 1 < progLen - 1 && !isTarget[i + 1]) begin
                    t  = i + 2 + int'(nextRand() % 32'(progLen - 2 - i));
                    rc = (rc == 5'd0) ? 5'd1 : rc;
                    isTarget[t] = 1'b1;
                    mem[i]      = {6'h0d, 5'd0, rc, 16'(t * 4)};
                    modelMem[i] = mem[i];
                    i = i + 1;
                    w = {6'h00, rc, 15'd0, 6'h08}; // Pair of ori then jr.
                end else begin
                    w = {6'h09, ra, rb, r[31:16]};
                end
            end
            16, 17: w = {6'h0f, 5'd0, rb, r[31:16]};
            default: w = {6'h09, ra, rb, r[31:16]};
        endcase
        mem[i]      = w;
        modelMem[i] = w;
        i = i + 1;
    end
    mem[progLen - 1]      = 32'h0000_000d;
    modelMem[progLen - 1] = 32'h0000_000d;
    for (int k = 0; k < 32; k++) begin
        modelRegs[k] = '0;
    end
    modelPc   = '0;
    modelHalt = 1'b0;
endtask

task automatic writeResult(input logic [4:0] id, input logic [dataWidth-1:0] val);
    if (id != 5'd0) begin
        mWe   = 1'b1;
        mId   = id;
        mData = val;
    end
endtask

// Executes one instruction by the ISA rules.
task automatic modelStep();
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] se;
    logic [31:0] ze;
    logic [31:0] npc;
    logic [31:0] addr;
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [4:0]  rd;
    logic [4:0]  rt;
    logic [4:0]  sh;
    mWe    = 1'b0;
    mId    = '0;
    mData  = '0;
    mStore = 1'b0;
    mPc    = modelPc;
    ins = modelMem[int'((modelPc & addrMask) >> 2)];
    op  = ins[31:26];
    fn  = ins[5:0];
    rt  = ins[20:16];
    rd  = ins[15:11];
    sh  = ins[10:6];
    a   = modelRegs[ins[25:21]];
    b   = modelRegs[rt];
    se  = {{16{ins[15]}}, ins[15:0]};
    ze  = {16'd0, ins[15:0]};
    npc = modelPc + 32'd4;
    addr = (a + se) & addrMask;
    case (op)
        6'h00: begin
            case (fn)
                6'h00: writeResult(rd, b << sh);
                6'h02: writeResult(rd, b >> sh);
                6'h03: writeResult(rd, $signed(b) >>> sh);
                6'h08: npc = a;
                6'h0a: if (b == 32'd0) writeResult(rd, a);
                6'h0b: if (b != 32'd0) writeResult(rd, a);
                6'h0d: modelHalt = 1'b1;
                6'h21: writeResult(rd, a + b);
                6'h23: writeResult(rd, a - b);
                6'h24: writeResult(rd, a & b);
                6'h25: writeResult(rd, a | b);
                6'h26: writeResult(rd, a ^ b);
                6'h27: writeResult(rd, ~(a | b));
                6'h2a: writeResult(rd, {31'd0, $signed(a) < $signed(b)});
                6'h2b: writeResult(rd, {31'd0, a < b});
                default: ;
            endcase
        end
        6'h02: npc = {modelPc[31:28], ins[25:0], 2'b00};
        6'h03: begin
            writeResult(5'd31, modelPc + 32'd4);
            npc = {modelPc[31:28], ins[25:0], 2'b00};
        end
        6'h04: if (a == b) npc = modelPc + 32'd4 + (se << 2);
        6'h05: if (a != b) npc = modelPc + 32'd4 + (se << 2);
        6'h09: writeResult(rt, a + se);
        6'h0a: writeResult(rt, {31'd0, $signed(a) < $signed(se)});
        6'h0b: writeResult(rt, {31'd0, a < se});
        6'h0c: writeResult(rt, a & ze);
        6'h0d: writeResult(rt, a | ze);
        6'h0e: writeResult(rt, a ^ ze);
        6'h0f: writeResult(rt, {ins[15:0], 16'd0});
        6'h23: writeResult(rt, modelMem[int'(addr >> 2)]);
        6'h2b: begin
            mStore     = 1'b1;
            mStoreAddr = addr;
            mStoreData = b;
            modelMem[int'(addr >> 2)] = b;
        end
        default: ;
    endcase
    if (mWe) begin
        modelRegs[mId] = mData;
    end
    modelPc = npc;
endtask

//--- verif/tbTop.sv
`timescale 1ns/1ps

module tbTop;
    import mipsPkg::*;

    localparam int memDepth    = 1024;
    localparam int progLen     = 40;
    localparam int progCount   = 4;
    localparam int resetCycles = 16;
    localparam int quietCycles = 6;
    localparam int cycleLimit  = (6 * progLen * progCount +
                                  (resetCycles + quietCycles + 2) * progCount) * 2;
    localparam logic [dataWidth-1:0] addrMask = dataWidth'(memDepth * 4 - 4);

    logic                  clk;
    logic                  rstN;
    logic                  resetReq;
    logic                  memRead;
    logic                  memWrite;
    logic [dataWidth-1:0]  memAddr;
    logic [dataWidth-1:0]  memWData;
    logic [dataWidth-1:0]  memRData;
    logic                  retire;
    logic [dataWidth-1:0]  retirePc;
    logic                  regWriteEnable;
    logic [regIdWidth-1:0] writeRegId;
    logic [dataWidth-1:0]  writeData;
    logic                  halted;

    logic [dataWidth-1:0] mem [memDepth];
    logic [dataWidth-1:0] seenAddr;
    logic [dataWidth-1:0] seenData;
    logic                 readPending;
    logic                 sawHalt;
    int                   pendIdx;
    int                   storeSeen;
    int                   errorCount = 0;
    int                   checkCount = 0;
    int                   retired = 0;
    int                   cycleCount = 0;
    int                   progIdx = 0;

    `include "tbModel.svh"

    tbClock #(.periodNs(40), .resetCycles(resetCycles)) clocking0 (
        .resetReq (resetReq),
        .clk      (clk),
        .rstN     (rstN)
    );

    mipsCore #(.memDepthWords(memDepth)) dut (
        .clk            (clk),
        .rstN           (rstN),
        .memRead        (memRead),
        .memWrite       (memWrite),
        .memAddr        (memAddr),
        .memWData       (memWData),
        .memRData       (memRData),
        .retire         (retire),
        .retirePc       (retirePc),
        .regWriteEnable (regWriteEnable),
        .writeRegId     (writeRegId),
        .writeData      (writeData),
        .halted         (halted)
    );

    task automatic checkWord(input string name, input logic [dataWidth-1:0] got,
                             input logic [dataWidth-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            $display("mismatch %s at pc 0x%0h: got 0x%0h expected 0x%0h", name, mPc, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkRegId(input string name, input logic [regIdWidth-1:0] got,
                              input logic [regIdWidth-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            $display("mismatch %s at pc 0x%0h: got 0x%0h expected 0x%0h", name, mPc, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            $display("mismatch %s at pc 0x%0h: got 0x%0h expected 0x%0h", name, mPc, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkRetire();
        if (modelHalt) begin
            $display("program %0d: core retired an instruction after break", progIdx);
            errorCount++;
        end else begin
            modelStep();
            retired++;
            checkWord("retirePc", retirePc, mPc);
            checkBit("regWriteEnable", regWriteEnable, mWe);
            if (mWe) begin
                checkRegId("writeRegId", writeRegId, mId);
                checkWord("writeData", writeData, mData);
            end
            if (mStore && storeSeen != 1) begin
                $display("program %0d: sw at pc 0x%0h made %0d memory writes instead of one",
                         progIdx, mPc, storeSeen);
                errorCount++;
            end else if (mStore) begin
                checkWord("memAddr", seenAddr, mStoreAddr);
                checkWord("memWData", seenData, mStoreData);
            end else if (storeSeen != 0) begin
                $display("program %0d: memory write from a non-store instruction at pc 0x%0h",
                         progIdx, mPc);
                errorCount++;
            end
        end
        storeSeen = 0;
    endtask

    // Memory answers a read on the next cycle and takes a write at once.
    always @(negedge clk) begin
        if (readPending) begin
            memRData = mem[pendIdx];
        end
        readPending = memRead;
        pendIdx     = int'((memAddr & addrMask) >> 2);
        if (!rstN) begin
            storeSeen = 0;
            sawHalt   = 1'b0;
        end else begin
            if (memWrite) begin
                mem[int'((memAddr & addrMask) >> 2)] = memWData;
                storeSeen++;
                seenAddr = memAddr;
                seenData = memWData;
            end
            if (sawHalt && (retire || memRead || memWrite)) begin
                $display("program %0d: core still active after halting", progIdx);
                errorCount++;
            end
            if (sawHalt && !halted) begin
                $display("program %0d: core left the halted state", progIdx);
                errorCount++;
            end
            if (retire) begin
                checkRetire();
            end
            if (halted) begin
                sawHalt = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: core did not halt within %0d cycles", cycleLimit);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        int errBefore;
        int retiredBefore;
        resetReq  = 1'b0;
        memRData  = '0;
        randState = 32'hf0d7d2ed;
        for (int p = 0; p < progCount; p++) begin
            progIdx = p;
            if (p > 0) begin
                resetReq = 1'b1;
                @(negedge clk);
                resetReq = 1'b0;
            end
            genProgram();
            errBefore     = errorCount;
            retiredBefore = retired;
            @(posedge rstN);
            while (!halted) @(negedge clk);
            repeat (quietCycles) @(negedge clk);
            if (!modelHalt) begin
                $display("program %0d: core halted before reaching break", p);
                errorCount++;
            end
            $display("program %0d: %0d instructions retired, %0d errors", p,
                     retired - retiredBefore, errorCount - errBefore);
        end
        $display("programs %0d, instructions %0d, checks %0d, errors %0d",
                 progCount, retired, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
